// File: src.f
hw/lsu_pkg.sv
hw/lsu_ad.sv
hw/lsu_sq.sv
hw/lsu_dmem.sv
hw/lsu_top.sv
bench/lsu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module lsu_tb -f src.f -o lsu_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: bench/lsu_cases.txt
# kind insn base store_data tag expected, all fields in hex
# expected is load data for a load, store tag for a commit, o_stall level for a stall
# word store, commit, then loads with positive and negative I immediates
issue  00002823 00000100 deadbeef 01 00000000
commit 00000000 00000000 00000000 00 00000001
issue  01002003 00000100 00000000 02 deadbeef
issue  ff002003 00000120 00000000 03 deadbeef
# byte and half stores into the word at 0x200, negative S immediate on the byte
issue  00002023 00000200 11223344 04 00000000
commit 00000000 00000000 00000000 00 00000004
issue  fe000823 00000211 000000a5 05 00000000
commit 00000000 00000000 00000000 00 00000005
issue  00001223 000001fe 12348001 06 00000000
commit 00000000 00000000 00000000 00 00000006
issue  00100003 00000200 00000000 07 ffffffa5
issue  00104003 00000200 00000000 08 000000a5
issue  ffe01003 00000204 00000000 09 ffff8001
issue  00205003 00000200 00000000 0a 00008001
issue  00001003 00000200 00000000 0b ffffa544
issue  00300003 00000200 00000000 0c ffffff80
issue  00004003 00000200 00000000 0d 00000044
issue  00002003 00000200 00000000 0e 8001a544
# three stores retire in allocation order
issue  00002023 00000300 a0a0a0a0 10 00000000
issue  00002223 00000300 b1b1b1b1 11 00000000
issue  00002423 00000300 c2c2c2c2 12 00000000
commit 00000000 00000000 00000000 00 00000010
commit 00000000 00000000 00000000 00 00000011
commit 00000000 00000000 00000000 00 00000012
issue  00002003 00000304 00000000 13 b1b1b1b1
issue  00802003 00000300 00000000 14 c2c2c2c2
# uncommitted stores are dropped by a flush
issue  00002023 00000110 55555555 15 00000000
issue  00002023 00000200 66666666 16 00000000
flush  00000000 00000000 00000000 00 00000000
issue  00002023 00000114 77777777 17 00000000
commit 00000000 00000000 00000000 00 00000017
issue  00002003 00000110 00000000 18 deadbeef
issue  00002003 00000200 00000000 19 8001a544
issue  00002003 00000114 00000000 1a 77777777
# fill the queue, stall, free one entry, then drain everything
issue  00002023 00000380 50000380 20 00000000
issue  00002223 00000380 50000384 21 00000000
issue  00002423 00000380 50000388 22 00000000
issue  00002623 00000380 5000038c 23 00000000
issue  00002823 00000380 50000390 24 00000000
issue  00002a23 00000380 50000394 25 00000000
issue  00002c23 00000380 50000398 26 00000000
issue  00002e23 00000380 5000039c 27 00000000
stall  00000000 00000000 00000000 00 00000001
commit 00000000 00000000 00000000 00 00000020
stall  00000000 00000000 00000000 00 00000000
issue  02002023 00000380 500003a0 28 00000000
commit 00000000 00000000 00000000 00 00000021
commit 00000000 00000000 00000000 00 00000022
commit 00000000 00000000 00000000 00 00000023
commit 00000000 00000000 00000000 00 00000024
commit 00000000 00000000 00000000 00 00000025
commit 00000000 00000000 00000000 00 00000026
commit 00000000 00000000 00000000 00 00000027
commit 00000000 00000000 00000000 00 00000028
issue  01c02003 00000380 00000000 29 5000039c
issue  00002003 000003a0 00000000 2a 500003a0

// File: bench/lsu_tb.sv
// Self-checking testbench for lsu_top, replays the operations listed in the cases file
`timescale 1ns/1ns
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int SQ_DEPTH  = 8;
    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 100;

    logic           clk;
    logic           n_rst;
    logic           i_flush;
    logic           i_commit;
    logic           i_valid;
    lsu_data_t      i_insn;
    lsu_opcode_t    i_opcode;
    lsu_data_t      i_src_a;
    lsu_data_t      i_src_b;
    lsu_tag_t       i_tag;
    logic           o_stall;
    logic           o_load_valid;
    lsu_tag_t       o_load_tag;
    lsu_data_t      o_load_data;
    logic           o_store_done;
    lsu_tag_t       o_store_tag;

    // Store completions, counted at the falling edge
    int             done_count = 0;
    lsu_tag_t       done_tag;
    int             commit_count = 0;

    lsu_top #(
        .SQ_DEPTH       (SQ_DEPTH),
        .MEM_WORDS      (MEM_WORDS)
    ) dut_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_commit       (i_commit),
        .i_valid        (i_valid),
        .i_insn         (i_insn),
        .i_opcode       (i_opcode),
        .i_src_a        (i_src_a),
        .i_src_b        (i_src_b),
        .i_tag          (i_tag),
        .o_stall        (o_stall),
        .o_load_valid   (o_load_valid),
        .o_load_tag     (o_load_tag),
        .o_load_data    (o_load_data),
        .o_store_done   (o_store_done),
        .o_store_tag    (o_store_tag)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (n_rst && o_store_done) begin
            done_count = done_count + 1;
            done_tag   = o_store_tag;
        end
    end

    task automatic fail_run(input string msg);
        $display("%0s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "test stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %0s: expected %08h, actual %08h", name, expected, actual);
            fail_run("Value check failed");
        end
    endtask

    // Advance one clock and land just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_op(input int case_no, input lsu_data_t insn, input lsu_data_t base,
                            input lsu_data_t data, input lsu_tag_t tag,
                            input lsu_data_t expected);
        int   cycles;
        logic is_load;
        is_load  = (insn[6:0] == OPCODE_LOAD);
        i_valid  = 1'b1;
        i_insn   = insn;
        i_opcode = insn[6:0];
        i_src_a  = base;
        i_src_b  = data;
        i_tag    = tag;
        cycles   = 0;
        while (o_stall) begin
            next_cycle();
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("Case %0d: o_stall never dropped", case_no));
            end
        end
        // Accepted at this edge
        next_cycle();
        i_valid = 1'b0;
        if (is_load) begin
            // Edges counted from the accepting edge
            cycles = 0;
            while (!o_load_valid) begin
                next_cycle();
                cycles++;
                if (cycles > TIMEOUT) begin
                    fail_run($sformatf("Case %0d: load result never arrived", case_no));
                end
            end
            check($sformatf("case %0d load latency", case_no), 32'd2, 32'(cycles));
            check($sformatf("case %0d load tag", case_no), 32'(tag), 32'(o_load_tag));
            check($sformatf("case %0d load data", case_no), expected, o_load_data);
        end else begin
            // Store lands in the queue on the next edge
            next_cycle();
        end
    endtask

    task automatic commit_store(input int case_no, input lsu_data_t expected);
        int cycles;
        int target;
        target   = done_count + 1;
        i_commit = 1'b1;
        next_cycle();
        i_commit = 1'b0;
        commit_count++;
        cycles = 0;
        while (done_count < target) begin
            next_cycle();
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("Case %0d: committed store never completed", case_no));
            end
        end
        check($sformatf("case %0d store tag", case_no), expected, 32'(done_tag));
    endtask

    task automatic pulse_flush();
        i_flush = 1'b1;
        next_cycle();
        i_flush = 1'b0;
    endtask

    initial begin
        int             fd;
        int             n;
        int             case_no;
        logic [63:0]    kind;
        logic [8*200-1:0] rest;
        lsu_data_t      insn;
        lsu_data_t      base;
        lsu_data_t      data;
        lsu_tag_t       tag;
        lsu_data_t      expected;

        n_rst    = 1'b0;
        i_flush  = 1'b0;
        i_commit = 1'b0;
        i_valid  = 1'b0;
        i_insn   = '0;
        i_opcode = '0;
        i_src_a  = '0;
        i_src_b  = '0;
        i_tag    = '0;
        repeat (16) @(posedge clk);
        #1;
        n_rst = 1'b1;
        check("reset o_stall", 32'd0, 32'(o_stall));
        check("reset o_load_valid", 32'd0, 32'(o_load_valid));
        check("reset o_store_done", 32'd0, 32'(o_store_done));

        fd = $fopen("bench/lsu_cases.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the cases file bench/lsu_cases.txt");
        end
        case_no = 0;
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                break;
            end
            if (kind == 64'("#")) begin
                n = $fgets(rest, fd);
                continue;
            end
            case_no++;
            n = $fscanf(fd, "%h %h %h %h %h", insn, base, data, tag, expected);
            if (n != 5) begin
                fail_run($sformatf("Case %0d: malformed line in the cases file", case_no));
            end
            if (kind == 64'("issue")) begin
                issue_op(case_no, insn, base, data, tag, expected);
            end else if (kind == 64'("commit")) begin
                commit_store(case_no, expected);
            end else if (kind == 64'("flush")) begin
                pulse_flush();
            end else if (kind == 64'("stall")) begin
                check($sformatf("case %0d o_stall", case_no), expected, 32'(o_stall));
            end else begin
                fail_run($sformatf("Case %0d: unknown operation kind", case_no));
            end
        end
        $fclose(fd);

        // Flushed stores must never have completed
        check("total store completions", 32'(commit_count), 32'(done_count));
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
// LSU front end top level, wires AD, store queue and data RAM stages together
`timescale 1ns/1ns
`default_nettype none

module lsu_top
    import lsu_pkg::*;
#(
    parameter int SQ_DEPTH  = 8,
    parameter int MEM_WORDS = 256
) (
    input  wire             clk,
    input  wire             n_rst,

    input  wire             i_flush,
    input  wire             i_commit,

    // Issue
    input  wire             i_valid,
    input  wire lsu_data_t  i_insn,
    input  wire lsu_opcode_t i_opcode,
    input  wire lsu_data_t  i_src_a,
    input  wire lsu_data_t  i_src_b,
    input  wire lsu_tag_t   i_tag,
    output logic            o_stall,

    // Results
    output logic            o_load_valid,
    output lsu_tag_t        o_load_tag,
    output lsu_data_t       o_load_data,
    output logic            o_store_done,
    output lsu_tag_t        o_store_tag
);

    // AD to store queue
    logic       alloc_en;
    lsu_func_t  alloc_func;
    lsu_tag_t   alloc_tag;
    lsu_data_t  alloc_addr;
    lsu_data_t  alloc_data;

    // Store queue to AD
    logic       sq_full;
    logic       retire_en;
    lsu_func_t  retire_func;
    lsu_tag_t   retire_tag;
    lsu_data_t  retire_addr;
    lsu_data_t  retire_data;
    logic       retire_ack;

    // AD to data RAM
    logic       op_valid;
    logic       op_store;
    lsu_func_t  op_func;
    lsu_tag_t   op_tag;
    lsu_data_t  op_addr;
    lsu_data_t  op_data;

    lsu_ad ad_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_valid        (i_valid),
        .i_insn         (i_insn),
        .i_opcode       (i_opcode),
        .i_src_a        (i_src_a),
        .i_src_b        (i_src_b),
        .i_tag          (i_tag),
        .o_stall        (o_stall),
        .i_sq_full      (sq_full),
        .i_retire_en    (retire_en),
        .i_retire_func  (retire_func),
        .i_retire_tag   (retire_tag),
        .i_retire_addr  (retire_addr),
        .i_retire_data  (retire_data),
        .o_retire_ack   (retire_ack),
        .o_alloc_en     (alloc_en),
        .o_alloc_func   (alloc_func),
        .o_alloc_tag    (alloc_tag),
        .o_alloc_addr   (alloc_addr),
        .o_alloc_data   (alloc_data),
        .o_op_valid     (op_valid),
        .o_op_store     (op_store),
        .o_op_func      (op_func),
        .o_op_tag       (op_tag),
        .o_op_addr      (op_addr),
        .o_op_data      (op_data)
    );

    lsu_sq #(
        .SQ_DEPTH       (SQ_DEPTH)
    ) sq_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_commit       (i_commit),
        .i_alloc_en     (alloc_en),
        .i_alloc_func   (alloc_func),
        .i_alloc_tag    (alloc_tag),
        .i_alloc_addr   (alloc_addr),
        .i_alloc_data   (alloc_data),
        .o_full         (sq_full),
        .o_retire_en    (retire_en),
        .o_retire_func  (retire_func),
        .o_retire_tag   (retire_tag),
        .o_retire_addr  (retire_addr),
        .o_retire_data  (retire_data),
        .i_retire_ack   (retire_ack)
    );

    lsu_dmem #(
        .MEM_WORDS      (MEM_WORDS)
    ) dmem_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_op_valid     (op_valid),
        .i_op_store     (op_store),
        .i_op_func      (op_func),
        .i_op_tag       (op_tag),
        .i_op_addr      (op_addr),
        .i_op_data      (op_data),
        .o_load_valid   (o_load_valid),
        .o_load_tag     (o_load_tag),
        .o_load_data    (o_load_data),
        .o_store_done   (o_store_done),
        .o_store_tag    (o_store_tag)
    );

endmodule

`default_nettype wire

// File: hw/lsu_dmem.sv
// Data RAM stage, writes retired stores and returns aligned, extended load data
`timescale 1ns/1ns
`default_nettype none

module lsu_dmem
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  wire             clk,
    input  wire             n_rst,

    // Op from the AD stage
    input  wire             i_op_valid,
    input  wire             i_op_store,
    input  wire lsu_func_t  i_op_func,
    input  wire lsu_tag_t   i_op_tag,
    input  wire lsu_data_t  i_op_addr,
    input  wire lsu_data_t  i_op_data,

    // Results
    output logic            o_load_valid,
    output lsu_tag_t        o_load_tag,
    output lsu_data_t       o_load_data,
    output logic            o_store_done,
    output lsu_tag_t        o_store_tag
);

    localparam int WA_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    lsu_data_t          mem [MEM_WORDS];

    logic [WA_W-1:0]    word_idx;
    logic [1:0]         byte_off;
    logic [3:0]         wr_be;
    lsu_data_t          wr_data;

    // First load stage holds the raw word
    logic               ld_valid_q;
    lsu_tag_t           ld_tag_q;
    lsu_func_t          ld_func_q;
    logic [1:0]         ld_off_q;
    lsu_data_t          ld_word_q;

    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;
    lsu_data_t          ld_result;

    assign word_idx = i_op_addr[WA_W+1:2];
    assign byte_off = i_op_addr[1:0];

    // Byte lanes and replicated data for the store
    always_comb begin
        case (i_op_func)
            LSU_FUNC_SB: begin
                wr_be   = 4'b0001 << byte_off;
                wr_data = {4{i_op_data[7:0]}};
            end
            LSU_FUNC_SH: begin
                wr_be   = 4'b0011 << {byte_off[1], 1'b0};
                wr_data = {2{i_op_data[15:0]}};
            end
            default: begin
                wr_be   = 4'b1111;
                wr_data = i_op_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_op_valid && i_op_store) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    mem[word_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Synchronous read
    always_ff @(posedge clk) begin
        if (i_op_valid && !i_op_store) begin
            ld_word_q <= mem[word_idx];
        end
        ld_tag_q  <= i_op_tag;
        ld_func_q <= i_op_func;
        ld_off_q  <= byte_off;
    end

    assign ld_byte = ld_word_q[8*ld_off_q +: 8];
    assign ld_half = ld_word_q[16*ld_off_q[1] +: 16];

    always_comb begin
        case (ld_func_q)
            LSU_FUNC_LB:  ld_result = {{(DATA_WIDTH-8){ld_byte[7]}}, ld_byte};
            LSU_FUNC_LBU: ld_result = {{(DATA_WIDTH-8){1'b0}}, ld_byte};
            LSU_FUNC_LH:  ld_result = {{(DATA_WIDTH-16){ld_half[15]}}, ld_half};
            LSU_FUNC_LHU: ld_result = {{(DATA_WIDTH-16){1'b0}}, ld_half};
            default:      ld_result = ld_word_q;
        endcase
    end

    always_ff @(posedge clk) begin
        o_load_tag  <= ld_tag_q;
        o_load_data <= ld_result;
        o_store_tag <= i_op_tag;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            ld_valid_q   <= 1'b0;
            o_load_valid <= 1'b0;
            o_store_done <= 1'b0;
        end else begin
            ld_valid_q   <= i_op_valid & ~i_op_store;
            o_load_valid <= ld_valid_q;
            o_store_done <= i_op_valid & i_op_store;
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_sq.sv
// Circular store queue, holds stores from allocation until commit and retirement
`timescale 1ns/1ns
`default_nettype none

module lsu_sq
    import lsu_pkg::*;
#(
    parameter int SQ_DEPTH = 8
) (
    input  wire             clk,
    input  wire             n_rst,

    input  wire             i_flush,
    input  wire             i_commit,

    // Allocation from the AD stage
    input  wire             i_alloc_en,
    input  wire lsu_func_t  i_alloc_func,
    input  wire lsu_tag_t   i_alloc_tag,
    input  wire lsu_data_t  i_alloc_addr,
    input  wire lsu_data_t  i_alloc_data,
    output logic            o_full,

    // Head entry offered for retirement
    output logic            o_retire_en,
    output lsu_func_t       o_retire_func,
    output lsu_tag_t        o_retire_tag,
    output lsu_data_t       o_retire_addr,
    output lsu_data_t       o_retire_data,
    input  wire             i_retire_ack
);

    localparam int IDX_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    // Entry storage
    lsu_func_t  q_func [SQ_DEPTH];
    lsu_tag_t   q_tag  [SQ_DEPTH];
    lsu_data_t  q_addr [SQ_DEPTH];
    lsu_data_t  q_data [SQ_DEPTH];

    logic [IDX_W-1:0] head_ptr;
    logic [IDX_W-1:0] cmt_ptr;
    logic [IDX_W-1:0] tail_ptr;
    logic [IDX_W-1:0] cmt_next;

    // Entries in use, and committed entries not yet retired
    logic [CNT_W-1:0] n_used;
    logic [CNT_W-1:0] n_cmt;
    logic [CNT_W-1:0] n_cmt_next;

    logic do_alloc;
    logic do_commit;
    logic do_retire;

    function automatic logic [IDX_W-1:0] ptr_inc(input logic [IDX_W-1:0] p);
        return (p == IDX_W'(SQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // A store arriving with a flush is still uncommitted and is dropped
    assign do_alloc  = i_alloc_en & ~i_flush;
    assign do_commit = i_commit & (n_used != n_cmt);
    assign do_retire = i_retire_ack & (n_cmt != '0);

    assign cmt_next   = do_commit ? ptr_inc(cmt_ptr) : cmt_ptr;
    assign n_cmt_next = n_cmt + CNT_W'(do_commit) - CNT_W'(do_retire);

    // Counts a store still in flight from AD so that one more accept is safe
    assign o_full = ({1'b0, n_used} + (CNT_W+1)'(i_alloc_en)) >= (CNT_W+1)'(SQ_DEPTH);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_ptr <= '0;
            cmt_ptr  <= '0;
            tail_ptr <= '0;
            n_used   <= '0;
            n_cmt    <= '0;
        end else begin
            cmt_ptr <= cmt_next;
            n_cmt   <= n_cmt_next;
            if (do_retire) begin
                head_ptr <= ptr_inc(head_ptr);
            end
            if (i_flush) begin
                // Only committed entries survive
                tail_ptr <= cmt_next;
                n_used   <= n_cmt_next;
            end else begin
                if (do_alloc) begin
                    tail_ptr <= ptr_inc(tail_ptr);
                end
                n_used <= n_used + CNT_W'(do_alloc) - CNT_W'(do_retire);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            q_func[tail_ptr] <= i_alloc_func;
            q_tag[tail_ptr]  <= i_alloc_tag;
            q_addr[tail_ptr] <= i_alloc_addr;
            q_data[tail_ptr] <= i_alloc_data;
        end
    end

    // Head entry is ready once it has been committed
    assign o_retire_en   = (n_cmt != '0);
    assign o_retire_func = q_func[head_ptr];
    assign o_retire_tag  = q_tag[head_ptr];
    assign o_retire_addr = q_addr[head_ptr];
    assign o_retire_data = q_data[head_ptr];

endmodule

`default_nettype wire

// File: hw/lsu_ad.sv
// Decode and address generation, picks a store retirement or a new issue each cycle
`timescale 1ns/1ns
`default_nettype none

module lsu_ad
    import lsu_pkg::*;
(
    input  wire             clk,
    input  wire             n_rst,

    input  wire             i_flush,

    // Issue side
    input  wire             i_valid,
    input  wire lsu_data_t  i_insn,
    input  wire lsu_opcode_t i_opcode,
    input  wire lsu_data_t  i_src_a,
    input  wire lsu_data_t  i_src_b,
    input  wire lsu_tag_t   i_tag,
    output logic            o_stall,

    // Store queue status and head entry
    input  wire             i_sq_full,
    input  wire             i_retire_en,
    input  wire lsu_func_t  i_retire_func,
    input  wire lsu_tag_t   i_retire_tag,
    input  wire lsu_data_t  i_retire_addr,
    input  wire lsu_data_t  i_retire_data,
    output logic            o_retire_ack,

    // Store allocation
    output logic            o_alloc_en,
    output lsu_func_t       o_alloc_func,
    output lsu_tag_t        o_alloc_tag,
    output lsu_data_t       o_alloc_addr,
    output lsu_data_t       o_alloc_data,

    // Op to the data RAM stage
    output logic            o_op_valid,
    output logic            o_op_store,
    output lsu_func_t       o_op_func,
    output lsu_tag_t        o_op_tag,
    output lsu_data_t       o_op_addr,
    output lsu_data_t       o_op_data
);

    lsu_func_t  issue_func;
    lsu_data_t  imm_i;
    lsu_data_t  imm_s;
    lsu_data_t  eff_addr;
    logic       is_load;
    logic       is_store;
    logic       retire_take;
    logic       accept;

    assign is_load  = (i_opcode == OPCODE_LOAD);
    assign is_store = (i_opcode == OPCODE_STORE);

    // I and S immediates, both sign extended from bit 31
    assign imm_i = {{(DATA_WIDTH-12){i_insn[31]}}, i_insn[31:20]};
    assign imm_s = {{(DATA_WIDTH-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};

    assign eff_addr = i_src_a + (is_store ? imm_s : imm_i);

    // The head stays visible for one cycle after the ack, so skip it then
    assign retire_take = i_retire_en & ~o_retire_ack;

    assign o_stall = i_sq_full | retire_take;
    assign accept  = i_valid & ~o_stall & ~i_flush;

    // Funct3 decode
    always_comb begin
        case (i_insn[14:12])
            3'b000:  issue_func = is_store ? LSU_FUNC_SB : LSU_FUNC_LB;
            3'b001:  issue_func = is_store ? LSU_FUNC_SH : LSU_FUNC_LH;
            3'b010:  issue_func = is_store ? LSU_FUNC_SW : LSU_FUNC_LW;
            3'b100:  issue_func = is_store ? LSU_FUNC_SW : LSU_FUNC_LBU;
            3'b101:  issue_func = is_store ? LSU_FUNC_SW : LSU_FUNC_LHU;
            default: issue_func = is_store ? LSU_FUNC_SW : LSU_FUNC_LW;
        endcase
    end

    // Allocation payload
    always_ff @(posedge clk) begin
        o_alloc_func <= issue_func;
        o_alloc_tag  <= i_tag;
        o_alloc_addr <= eff_addr;
        o_alloc_data <= i_src_b;
    end

    // Op payload, retirement has priority over a new load
    always_ff @(posedge clk) begin
        o_op_func <= retire_take ? i_retire_func : issue_func;
        o_op_tag  <= retire_take ? i_retire_tag  : i_tag;
        o_op_addr <= retire_take ? i_retire_addr : eff_addr;
        o_op_data <= i_retire_data;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_alloc_en   <= 1'b0;
            o_retire_ack <= 1'b0;
            o_op_valid   <= 1'b0;
            o_op_store   <= 1'b0;
        end else begin
            // Stores only ever reach the RAM through the queue
            o_alloc_en   <= accept & is_store;
            o_retire_ack <= retire_take & ~i_flush;
            o_op_valid   <= ~i_flush & (retire_take | (accept & is_load));
            o_op_store   <= retire_take;
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_pkg.sv
// Widths, opcodes and access-function encodings that every LSU module imports
`default_nettype none

package lsu_pkg;

    // Data path and address width
    localparam int DATA_WIDTH = 32;

    // Tag that follows an op from issue to its result
    localparam int TAG_WIDTH = 6;

    typedef logic [DATA_WIDTH-1:0] lsu_data_t;
    typedef logic [TAG_WIDTH-1:0]  lsu_tag_t;

    // RV32 major opcode, bits [6:0] of the instruction
    typedef logic [6:0] lsu_opcode_t;

    localparam lsu_opcode_t OPCODE_LOAD  = 7'b0000011;
    localparam lsu_opcode_t OPCODE_STORE = 7'b0100011;

    // Access function decoded from opcode and funct3
    typedef enum logic [3:0] {
        LSU_FUNC_LB  = 4'b0000,
        LSU_FUNC_LH  = 4'b0001,
        LSU_FUNC_LW  = 4'b0010,
        LSU_FUNC_LBU = 4'b0100,
        LSU_FUNC_LHU = 4'b0101,
        LSU_FUNC_SB  = 4'b1000,
        LSU_FUNC_SH  = 4'b1001,
        LSU_FUNC_SW  = 4'b1010
    } lsu_func_t;

endpackage

`default_nettype wire
